// ==== verilog.f ====
+incdir+source
source/rv_pkg.sv
source/control_unit.sv
source/if_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/datapath.sv
source/rv_core.sv
verif/tb_memory.sv
verif/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - source/rv_pkg.sv
  - source/control_unit.sv
  - source/if_stage.sv
  - source/id_stage.sv
  - source/ex_stage.sv
  - source/datapath.sv
  - source/rv_core.sv
  - target: test
    files:
      - verif/tb_memory.sv
      - verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_ROW = 40;
    // six taken branches plus jal and jalr
    localparam int TAKEN_JUMPS    = 8;

    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    logic        clk   = 1'b0;
    logic        rst_i = 1'b1;
    logic [31:0] instr;
    logic [31:0] load_data;
    logic [31:0] rom_addr;
    logic [31:0] ram_addr;
    logic [31:0] store_data;
    logic        r_en;
    logic        w_en;
    logic        stat_flush;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];

    int row_idx     = 0;
    int pass_count  = 0;
    int error_count = 0;
    int flush_count = 0;

    always #4 clk = ~clk;

    rv_core i_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .instr_i      (instr),
        .load_data_i  (load_data),
        .rom_addr_o   (rom_addr),
        .ram_addr_o   (ram_addr),
        .store_data_o (store_data),
        .r_en_o       (r_en),
        .w_en_o       (w_en),
        .stat_flush_o (stat_flush)
    );

    tb_memory i_mem (
        .clk          (clk),
        .rom_addr_i   (rom_addr),
        .instr_o      (instr),
        .r_en_i       (r_en),
        .w_en_i       (w_en),
        .ram_addr_i   (ram_addr),
        .store_data_i (store_data),
        .load_data_o  (load_data)
    );

    ///////////////////////////////////////////////////////////////////////
    // rv32i encoders

    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic check_value(input string label, input string sig, input logic [31:0] got,
                               input logic [31:0] exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("FAIL %0t ns %s: %s got %h expected %h", $time, label, sig, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                                input string name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_name.push_back(name);
    endtask

    task automatic build_program();
        prog.push_back(i_type(OP_IMM, 0, 1, 0, 5));
        prog.push_back(i_type(OP_IMM, 0, 2, 0, -3));
        prog.push_back(r_type(7'h00, 0, 3, 1, 2));
        prog.push_back(store_word(3, 0, 'h100));
        prog.push_back(r_type(7'h20, 0, 4, 1, 2));
        prog.push_back(store_word(4, 0, 'h104));
        prog.push_back(r_type(7'h00, 7, 5, 1, 2));
        prog.push_back(store_word(5, 0, 'h108));
        prog.push_back(r_type(7'h00, 6, 6, 1, 2));
        prog.push_back(store_word(6, 0, 'h10C));
        prog.push_back(r_type(7'h00, 4, 7, 1, 2));
        prog.push_back(store_word(7, 0, 'h110));
        prog.push_back(r_type(7'h00, 1, 8, 1, 1));
        prog.push_back(store_word(8, 0, 'h114));
        prog.push_back(r_type(7'h00, 5, 9, 2, 1));
        prog.push_back(store_word(9, 0, 'h118));
        prog.push_back(r_type(7'h20, 5, 10, 2, 1));
        prog.push_back(store_word(10, 0, 'h11C));
        prog.push_back(r_type(7'h00, 2, 11, 2, 1));
        prog.push_back(store_word(11, 0, 'h120));
        prog.push_back(r_type(7'h00, 3, 12, 2, 1));
        prog.push_back(store_word(12, 0, 'h124));
        prog.push_back(i_type(OP_IMM, 2, 13, 2, -2));
        prog.push_back(store_word(13, 0, 'h128));
        prog.push_back(i_type(OP_IMM, 3, 14, 1, -1));
        prog.push_back(store_word(14, 0, 'h12C));
        // srai carries bit 30 in the immediate
        prog.push_back(i_type(OP_IMM, 5, 15, 2, 'h401));
        prog.push_back(store_word(15, 0, 'h130));
        prog.push_back(i_type(OP_IMM, 5, 16, 2, 28));
        prog.push_back(store_word(16, 0, 'h134));
        prog.push_back(i_type(OP_IMM, 1, 17, 1, 3));
        prog.push_back(store_word(17, 0, 'h138));
        prog.push_back(i_type(OP_IMM, 7, 18, 2, 'hF0));
        prog.push_back(store_word(18, 0, 'h13C));
        prog.push_back(i_type(OP_IMM, 6, 19, 1, 'h100));
        prog.push_back(store_word(19, 0, 'h140));
        prog.push_back(i_type(OP_IMM, 4, 20, 1, -1));
        prog.push_back(store_word(20, 0, 'h144));
        // dependent chain at pc 0x98
        prog.push_back(i_type(OP_IMM, 0, 21, 0, 7));
        prog.push_back(i_type(OP_IMM, 0, 21, 21, 1));
        prog.push_back(r_type(7'h00, 0, 22, 21, 21));
        prog.push_back(r_type(7'h00, 0, 23, 21, 22));
        prog.push_back(store_word(22, 0, 'h148));
        prog.push_back(store_word(23, 0, 'h14C));
        // load then immediate use
        prog.push_back(i_type(OP_IMM, 0, 24, 0, 100));
        prog.push_back(store_word(24, 0, 'h200));
        prog.push_back(i_type(OP_LOAD, 2, 25, 0, 'h200));
        prog.push_back(r_type(7'h00, 0, 26, 25, 24));
        prog.push_back(store_word(26, 0, 'h204));
        // each kind taken over a bad store, then not taken into a marker store
        for (int k = 0; k < 6; k++) begin
            int f3;
            f3 = (k < 2) ? k : k + 2;
            if (k == 0 || k == 3) begin
                prog.push_back(b_type(f3, 1, (k == 0) ? 1 : 2, 8));
            end else begin
                prog.push_back(b_type(f3, (k == 1 || k == 4) ? 1 : 2,
                                      (k == 1 || k == 4) ? 2 : 1, 8));
            end
            prog.push_back(store_word(2, 0, 'h3FC));
            if (k == 1) begin
                prog.push_back(b_type(f3, 1, 1, 8));
            end else if (k == 0) begin
                prog.push_back(b_type(f3, 1, 2, 8));
            end else begin
                prog.push_back(b_type(f3, (k == 2 || k == 5) ? 1 : 2,
                                      (k == 2 || k == 5) ? 2 : 1, 8));
            end
            prog.push_back(store_word(1, 0, 'h300 + 4 * k));
        end
        // jal at pc 0x124
        prog.push_back(j_type(27, 12));
        prog.push_back(store_word(2, 0, 'h3FC));
        prog.push_back(store_word(2, 0, 'h3FC));
        prog.push_back(store_word(27, 0, 'h380));
        // auipc at 0x134, jalr at 0x138 lands on 0x144
        prog.push_back(u_type(OP_AUIPC, 28, 0));
        prog.push_back(i_type(OP_JALR, 0, 29, 28, 17));
        prog.push_back(store_word(2, 0, 'h3FC));
        prog.push_back(store_word(2, 0, 'h3FC));
        prog.push_back(store_word(29, 0, 'h384));
        prog.push_back(u_type(OP_LUI, 30, 'h12345));
        prog.push_back(store_word(30, 0, 'h390));
        // auipc at 0x150
        prog.push_back(u_type(OP_AUIPC, 31, 1));
        prog.push_back(store_word(31, 0, 'h394));
        prog.push_back(i_type(OP_IMM, 0, 0, 1, 9));
        prog.push_back(store_word(0, 0, 'h398));
    endtask

    task automatic build_expectations();
        expect_store(32'h100, 32'h0000_0002, "add");
        expect_store(32'h104, 32'h0000_0008, "sub");
        expect_store(32'h108, 32'h0000_0005, "and");
        expect_store(32'h10C, 32'hFFFF_FFFD, "or");
        expect_store(32'h110, 32'hFFFF_FFF8, "xor");
        expect_store(32'h114, 32'h0000_00A0, "sll");
        expect_store(32'h118, 32'h07FF_FFFF, "srl");
        expect_store(32'h11C, 32'hFFFF_FFFF, "sra");
        expect_store(32'h120, 32'h0000_0001, "slt negative");
        expect_store(32'h124, 32'h0000_0000, "sltu negative");
        expect_store(32'h128, 32'h0000_0001, "slti");
        expect_store(32'h12C, 32'h0000_0001, "sltiu");
        expect_store(32'h130, 32'hFFFF_FFFE, "srai");
        expect_store(32'h134, 32'h0000_000F, "srli");
        expect_store(32'h138, 32'h0000_0028, "slli");
        expect_store(32'h13C, 32'h0000_00F0, "andi");
        expect_store(32'h140, 32'h0000_0105, "ori");
        expect_store(32'h144, 32'hFFFF_FFFA, "xori");
        expect_store(32'h148, 32'h0000_0010, "forward ex/mem");
        expect_store(32'h14C, 32'h0000_0018, "forward mem/wb");
        expect_store(32'h200, 32'h0000_0064, "load setup");
        expect_store(32'h204, 32'h0000_00C8, "load-use stall");
        expect_store(32'h300, 32'h0000_0005, "beq");
        expect_store(32'h304, 32'h0000_0005, "bne");
        expect_store(32'h308, 32'h0000_0005, "blt");
        expect_store(32'h30C, 32'h0000_0005, "bge");
        expect_store(32'h310, 32'h0000_0005, "bltu");
        expect_store(32'h314, 32'h0000_0005, "bgeu");
        expect_store(32'h380, 32'h0000_0128, "jal link");
        expect_store(32'h384, 32'h0000_013C, "jalr link");
        expect_store(32'h390, 32'h1234_5000, "lui");
        expect_store(32'h394, 32'h0000_1150, "auipc");
        expect_store(32'h398, 32'h0000_0000, "x0 write");
    endtask

    ///////////////////////////////////////////////////////////////////////
    // store monitor and flush counter

    always @(negedge clk) begin : store_monitor
        bit addr_ok;
        bit data_ok;
        if (!rst_i) begin
            if (stat_flush) begin
                flush_count++;
            end
            if (w_en && row_idx < exp_addr.size()) begin
                check_value(exp_name[row_idx], "ram_addr_o", ram_addr, exp_addr[row_idx],
                            addr_ok);
                check_value(exp_name[row_idx], "store_data_o", store_data,
                            exp_data[row_idx], data_ok);
                if (addr_ok && data_ok) begin
                    $display("pass %s", exp_name[row_idx]);
                    pass_count++;
                end
                row_idx++;
            end
        end
    end

    initial begin : main_flow
        int unsigned rng_seed;
        int unsigned discard;
        bit          flush_ok;
        rng_seed = 32'h227a;
        discard  = $urandom(rng_seed);
        build_program();
        build_expectations();
        @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            i_mem.rom[i] <= prog[i];
        end
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            i_mem.ram[i] <= $urandom ^ i;
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_i <= 1'b0;
        wait (row_idx == exp_addr.size());
        check_value("branch flush", "stat_flush_o pulses", flush_count, TAKEN_JUMPS,
                    flush_ok);
        if (flush_ok) begin
            $display("pass branch flush count");
        end
        $display("rows %0d, passed %0d, flush pulses %0d, errors %0d",
                 exp_addr.size(), pass_count, flush_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (!rst_i);
        repeat (CYCLES_PER_ROW * exp_addr.size()) @(posedge clk);
        $display("timeout: stores stopped after %0d of %0d rows", row_idx, exp_addr.size());
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verif/tb_memory.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_memory (
    input  logic        clk,
    input  logic [31:0] rom_addr_i,
    output logic [31:0] instr_o,
    input  logic        r_en_i,
    input  logic        w_en_i,
    input  logic [31:0] ram_addr_i,
    input  logic [31:0] store_data_i,
    output logic [31:0] load_data_o
);

    localparam int AW = $clog2(`RV_MEM_WORDS);

    logic [31:0] rom [`RV_MEM_WORDS];
    logic [31:0] ram [`RV_MEM_WORDS];

    // empty rom words decode as no-ops
    initial begin
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            rom[i] = '0;
        end
    end

    // word addressed, combinational read
    assign instr_o     = rom[rom_addr_i[AW+1:2]];
    assign load_data_o = r_en_i ? ram[ram_addr_i[AW+1:2]] : '0;

    always @(posedge clk) begin
        if (w_en_i) begin
            ram[ram_addr_i[AW+1:2]] <= store_data_i;
        end
    end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  word_t instr_i,
    input  word_t load_data_i,

    output word_t rom_addr_o,
    output word_t ram_addr_o,
    output word_t store_data_o,
    output logic  r_en_o,
    output logic  w_en_o,
    output logic  stat_flush_o
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       func7;
    logic       alu_src_pc, alu_src_imm;
    alu_ctl_t   alu_ctl;
    logic       is_branch, jal, jalr;
    logic       reg_write, mem_read, mem_write;

    datapath datapath_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .load_data_i   (load_data_i),
        .alu_src_pc_i  (alu_src_pc),
        .alu_src_imm_i (alu_src_imm),
        .alu_ctl_i     (alu_ctl),
        .is_branch_i   (is_branch),
        .jal_i         (jal),
        .jalr_i        (jalr),
        .reg_write_i   (reg_write),
        .mem_read_i    (mem_read),
        .mem_write_i   (mem_write),
        .opcode_o      (opcode),
        .func3_o       (func3),
        .func7_o       (func7),
        .rom_addr_o    (rom_addr_o),
        .ram_addr_o    (ram_addr_o),
        .store_data_o  (store_data_o),
        .r_en_o        (r_en_o),
        .w_en_o        (w_en_o),
        .stat_flush_o  (stat_flush_o)
    );

    control_unit control_unit_inst (
        .opcode_i      (opcode),
        .func3_i       (func3),
        .func7_i       (func7),
        .alu_src_pc_o  (alu_src_pc),
        .alu_src_imm_o (alu_src_imm),
        .alu_ctl_o     (alu_ctl),
        .is_branch_o   (is_branch),
        .jal_o         (jal),
        .jalr_o        (jalr),
        .reg_write_o   (reg_write),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write)
    );

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  word_t      instr_i,
    input  word_t      load_data_i,

    input  logic       alu_src_pc_i,
    input  logic       alu_src_imm_i,
    input  alu_ctl_t   alu_ctl_i,
    input  logic       is_branch_i,
    input  logic       jal_i,
    input  logic       jalr_i,
    input  logic       reg_write_i,
    input  logic       mem_read_i,
    input  logic       mem_write_i,

    output logic [6:0] opcode_o,
    output logic [2:0] func3_o,
    output logic       func7_o,
    output word_t      rom_addr_o,
    output word_t      ram_addr_o,
    output word_t      store_data_o,
    output logic       r_en_o,
    output logic       w_en_o,
    output logic       stat_flush_o
);

    logic       stall;
    logic       flush;
    word_t      target;
    word_t      pc;

    word_t      if_id_pc;
    word_t      if_id_instr;

    word_t      id_rs1_data, id_rs2_data, id_imm;
    reg_addr_t  id_rs1, id_rs2, id_rd;

    word_t      id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    reg_addr_t  id_ex_rs1, id_ex_rs2, id_ex_rd;
    logic [2:0] id_ex_func3;
    logic       id_ex_alu_src_pc, id_ex_alu_src_imm;
    alu_ctl_t   id_ex_alu_ctl;
    logic       id_ex_is_branch, id_ex_jal, id_ex_jalr;
    logic       id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;

    word_t      ex_result, ex_store_data;

    word_t      ex_mem_result, ex_mem_store_data;
    reg_addr_t  ex_mem_rd;
    logic       ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;

    word_t      mem_data;
    word_t      mem_wb_data;
    reg_addr_t  mem_wb_rd;
    logic       mem_wb_reg_write;

    if_stage if_stage_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .stall_i    (stall),
        .redirect_i (flush),
        .target_i   (target),
        .pc_o       (pc)
    );

    assign rom_addr_o = pc;

    ///////////////////////////////////////////////////////////////////////
    // if/id

    always_ff @(posedge clk) begin
        if (rst_i || flush) begin
            if_id_instr <= '0;
        end else if (!stall) begin
            if_id_instr <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

    assign opcode_o = if_id_instr[6:0];
    assign func3_o  = if_id_instr[14:12];
    assign func7_o  = if_id_instr[30];

    id_stage id_stage_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_i       (if_id_instr),
        .wb_en_i       (mem_wb_reg_write),
        .wb_rd_i       (mem_wb_rd),
        .wb_data_i     (mem_wb_data),
        .ex_mem_read_i (id_ex_mem_read),
        .ex_rd_i       (id_ex_rd),
        .rs1_data_o    (id_rs1_data),
        .rs2_data_o    (id_rs2_data),
        .imm_o         (id_imm),
        .rs1_o         (id_rs1),
        .rs2_o         (id_rs2),
        .rd_o          (id_rd),
        .stall_o       (stall)
    );

    ///////////////////////////////////////////////////////////////////////
    // id/ex

    // stall or flush turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (rst_i || flush || stall) begin
            id_ex_alu_src_pc  <= 1'b0;
            id_ex_alu_src_imm <= 1'b0;
            id_ex_alu_ctl     <= ALU_ADD;
            id_ex_is_branch   <= 1'b0;
            id_ex_jal         <= 1'b0;
            id_ex_jalr        <= 1'b0;
            id_ex_reg_write   <= 1'b0;
            id_ex_mem_read    <= 1'b0;
            id_ex_mem_write   <= 1'b0;
        end else begin
            id_ex_alu_src_pc  <= alu_src_pc_i;
            id_ex_alu_src_imm <= alu_src_imm_i;
            id_ex_alu_ctl     <= alu_ctl_i;
            id_ex_is_branch   <= is_branch_i;
            id_ex_jal         <= jal_i;
            id_ex_jalr        <= jalr_i;
            id_ex_reg_write   <= reg_write_i;
            id_ex_mem_read    <= mem_read_i;
            id_ex_mem_write   <= mem_write_i;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc       <= if_id_pc;
        id_ex_rs1_data <= id_rs1_data;
        id_ex_rs2_data <= id_rs2_data;
        id_ex_imm      <= id_imm;
        id_ex_rs1      <= id_rs1;
        id_ex_rs2      <= id_rs2;
        id_ex_rd       <= id_rd;
        id_ex_func3    <= if_id_instr[14:12];
    end

    ex_stage ex_stage_inst (
        .pc_i            (id_ex_pc),
        .rs1_data_i      (id_ex_rs1_data),
        .rs2_data_i      (id_ex_rs2_data),
        .imm_i           (id_ex_imm),
        .rs1_i           (id_ex_rs1),
        .rs2_i           (id_ex_rs2),
        .func3_i         (id_ex_func3),
        .alu_src_pc_i    (id_ex_alu_src_pc),
        .alu_src_imm_i   (id_ex_alu_src_imm),
        .alu_ctl_i       (id_ex_alu_ctl),
        .is_branch_i     (id_ex_is_branch),
        .jal_i           (id_ex_jal),
        .jalr_i          (id_ex_jalr),
        .mem_rd_i        (ex_mem_rd),
        .mem_reg_write_i (ex_mem_reg_write),
        .mem_result_i    (ex_mem_result),
        .wb_rd_i         (mem_wb_rd),
        .wb_reg_write_i  (mem_wb_reg_write),
        .wb_data_i       (mem_wb_data),
        .result_o        (ex_result),
        .store_data_o    (ex_store_data),
        .redirect_o      (flush),
        .target_o        (target)
    );

    assign stat_flush_o = flush;

    ///////////////////////////////////////////////////////////////////////
    // ex/mem and mem/wb

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            mem_wb_reg_write <= 1'b0;
        end else begin
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_result     <= ex_result;
        ex_mem_store_data <= ex_store_data;
        ex_mem_rd         <= id_ex_rd;
        mem_wb_data       <= mem_data;
        mem_wb_rd         <= ex_mem_rd;
    end

    // load data or alu result heads to write-back
    assign mem_data = ex_mem_mem_read ? load_data_i : ex_mem_result;

    assign r_en_o       = ex_mem_mem_read;
    assign w_en_o       = ex_mem_mem_write;
    assign ram_addr_o   = ex_mem_result;
    assign store_data_o = ex_mem_store_data;

endmodule

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import rv_pkg::*; (
    input  word_t      pc_i,
    input  word_t      rs1_data_i,
    input  word_t      rs2_data_i,
    input  word_t      imm_i,
    input  reg_addr_t  rs1_i,
    input  reg_addr_t  rs2_i,
    input  logic [2:0] func3_i,

    input  logic       alu_src_pc_i,
    input  logic       alu_src_imm_i,
    input  alu_ctl_t   alu_ctl_i,
    input  logic       is_branch_i,
    input  logic       jal_i,
    input  logic       jalr_i,

    input  reg_addr_t  mem_rd_i,
    input  logic       mem_reg_write_i,
    input  word_t      mem_result_i,
    input  reg_addr_t  wb_rd_i,
    input  logic       wb_reg_write_i,
    input  word_t      wb_data_i,

    output word_t      result_o,
    output word_t      store_data_o,
    output logic       redirect_o,
    output word_t      target_o
);

    word_t fwd_a;
    word_t fwd_b;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic  taken;

    // newest producer first
    assign fwd_a = (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == rs1_i) ? mem_result_i :
                   (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == rs1_i) ? wb_data_i :
                   rs1_data_i;
    assign fwd_b = (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == rs2_i) ? mem_result_i :
                   (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == rs2_i) ? wb_data_i :
                   rs2_data_i;

    assign op_a = alu_src_pc_i ? pc_i : fwd_a;
    assign op_b = alu_src_imm_i ? imm_i : fwd_b;

    always_comb begin
        case (alu_ctl_i)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_PASS: alu_out = op_b;
            default:  alu_out = '0;
        endcase
    end

    // link value for jal and jalr
    assign result_o     = (jal_i || jalr_i) ? pc_i + 32'd4 : alu_out;
    assign store_data_o = fwd_b;

    always_comb begin
        case (func3_i)
            3'b000:  taken = (fwd_a == fwd_b);
            3'b001:  taken = (fwd_a != fwd_b);
            3'b100:  taken = ($signed(fwd_a) < $signed(fwd_b));
            3'b101:  taken = ($signed(fwd_a) >= $signed(fwd_b));
            3'b110:  taken = (fwd_a < fwd_b);
            3'b111:  taken = (fwd_a >= fwd_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = (is_branch_i && taken) || jal_i || jalr_i;
    assign target_o   = jalr_i ? ((fwd_a + imm_i) & ~32'd1) : pc_i + imm_i;

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module id_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  word_t     instr_i,
    input  logic      wb_en_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    input  logic      ex_mem_read_i,
    input  reg_addr_t ex_rd_i,

    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output word_t     imm_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o,
    output logic      stall_o
);

    word_t      regs [`RV_NUM_REGS];
    logic [6:0] opcode;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = instr_i[6:0];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // write-first so wb and id can share a cycle
    assign rs1_data_o = (rs1_o == '0) ? '0 :
                        (wb_en_i && wb_rd_i == rs1_o) ? wb_data_i : regs[rs1_o];
    assign rs2_data_o = (rs2_o == '0) ? '0 :
                        (wb_en_i && wb_rd_i == rs2_o) ? wb_data_i : regs[rs2_o];

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            OPC_STORE:
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            OPC_BRANCH:
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm_o = {instr_i[31:12], 12'b0};
            OPC_JAL:
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // load-use detection

    assign use_rs1 = !(opcode == OPC_LUI || opcode == OPC_AUIPC || opcode == OPC_JAL);
    assign use_rs2 = (opcode == OPC_OP) || (opcode == OPC_STORE) || (opcode == OPC_BRANCH);

    assign stall_o = ex_mem_read_i && (ex_rd_i != '0) &&
                     ((use_rs1 && ex_rd_i == rs1_o) || (use_rs2 && ex_rd_i == rs2_o));

endmodule

// ==== source/if_stage.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module if_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  word_t target_i,
    output word_t pc_o
);

    word_t pc_q;

    // redirect from ex wins over a load-use hold
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  logic [6:0] opcode_i,
    input  logic [2:0] func3_i,
    input  logic       func7_i,

    output logic       alu_src_pc_o,
    output logic       alu_src_imm_o,
    output alu_ctl_t   alu_ctl_o,
    output logic       is_branch_o,
    output logic       jal_o,
    output logic       jalr_o,
    output logic       reg_write_o,
    output logic       mem_read_o,
    output logic       mem_write_o
);

    always_comb begin
        // unknown opcodes fall through as a no-op
        alu_src_pc_o  = 1'b0;
        alu_src_imm_o = 1'b0;
        alu_ctl_o     = ALU_ADD;
        is_branch_o   = 1'b0;
        jal_o         = 1'b0;
        jalr_o        = 1'b0;
        reg_write_o   = 1'b0;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;

        case (opcode_i)
            OPC_OP: begin
                alu_ctl_o   = {func7_i, func3_i};
                reg_write_o = 1'b1;
            end
            OPC_OP_IMM: begin
                // only srai borrows bit 30, addi has no subtract form
                alu_ctl_o     = {func7_i & (func3_i == 3'b101), func3_i};
                alu_src_imm_o = 1'b1;
                reg_write_o   = 1'b1;
            end
            OPC_LUI: begin
                alu_ctl_o     = ALU_PASS;
                alu_src_imm_o = 1'b1;
                reg_write_o   = 1'b1;
            end
            OPC_AUIPC: begin
                alu_src_pc_o  = 1'b1;
                alu_src_imm_o = 1'b1;
                reg_write_o   = 1'b1;
            end
            OPC_LOAD: begin
                alu_src_imm_o = 1'b1;
                reg_write_o   = 1'b1;
                mem_read_o    = 1'b1;
            end
            OPC_STORE: begin
                alu_src_imm_o = 1'b1;
                mem_write_o   = 1'b1;
            end
            OPC_BRANCH: is_branch_o = 1'b1;
            OPC_JAL: begin
                jal_o       = 1'b1;
                reg_write_o = 1'b1;
            end
            OPC_JALR: begin
                jalr_o      = 1'b1;
                reg_write_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_ctl_t;

    // top bit selects sub or sra and the low bits follow func3
    localparam alu_ctl_t ALU_ADD  = 4'b0000;
    localparam alu_ctl_t ALU_SLL  = 4'b0001;
    localparam alu_ctl_t ALU_SLT  = 4'b0010;
    localparam alu_ctl_t ALU_SLTU = 4'b0011;
    localparam alu_ctl_t ALU_XOR  = 4'b0100;
    localparam alu_ctl_t ALU_SRL  = 4'b0101;
    localparam alu_ctl_t ALU_OR   = 4'b0110;
    localparam alu_ctl_t ALU_AND  = 4'b0111;
    localparam alu_ctl_t ALU_SUB  = 4'b1000;
    localparam alu_ctl_t ALU_SRA  = 4'b1101;
    localparam alu_ctl_t ALU_PASS = 4'b1111;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

// ==== source/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// architectural integer registers
`define RV_NUM_REGS 32

// depth in words of each memory model
`define RV_MEM_WORDS 256

`endif
